/* project.f */
+incdir+dv
hdl/invadersPkg.sv
hdl/keyDecoder.sv
hdl/roundControl.sv
hdl/shipBullet.sv
hdl/enemyField.sv
hdl/statusDisplay.sv
hdl/spaceInvaders.sv
dv/tbSpaceInvaders.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tbSpaceInvaders
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/tbScanTasks.svh */
// one byte with a one-cycle valid, returns on the negedge after it is taken
task sendByte(input logic [7:0] code);
	@(posedge CLOCK_50);
	scanByte <= code;
	scanValid <= 1'b1;
	@(posedge CLOCK_50);
	scanValid <= 1'b0;
	@(negedge CLOCK_50);
endtask

// a tick seen at the current negedge counts too
task waitTicks(input int count);
	repeat (count) begin
		while (!u_spaceInvaders.frameTick)
			@(negedge CLOCK_50);
		@(negedge CLOCK_50); // frame update now visible
	end
endtask

task waitForLed(input int idx, input int maxFrames, output logic [2:0] hits);
	int n;
	logic seen;
	hits = '0;
	n = 0;
	seen = 1'b0;
	while (!seen && n < maxFrames) begin
		waitTicks(1);
		hits |= LEDR[9:7];
		seen = LEDR[idx];
		n++;
	end
	if (!seen) begin
		errors++;
		$display("Failure: no hit shown on LEDR[%0d] within %0d frames", idx, maxFrames);
	end
endtask

task runKeyRow(input keyRow_t row);
	string name;
	name = $sformatf("LEDR[3:0] after %h", row.code);
	sendByte(row.code);
	checkValue(name, LEDR[3:0], row.keys);
endtask

/* dv/tbSpaceInvaders.sv */
`default_nettype none

module tbSpaceInvaders;

	localparam int FRAME_CYCLES = 4;
	localparam int SECOND_FRAMES = 20;
	localparam int TIME_LIMIT = 3;
	localparam int WIN_SCORE = 1;
	// scenarios need about 1 + 5 + 62 + 63 + 40 + 62 frames plus resets
	localparam int TOTAL_FRAMES = 250;
	localparam int CYCLE_LIMIT = 4 * TOTAL_FRAMES * FRAME_CYCLES;

	// active low, bit 0 is segment a
	localparam logic [6:0] SEG_0 = 7'h40;
	localparam logic [6:0] SEG_1 = 7'h79;
	localparam logic [6:0] SEG_2 = 7'h24;
	localparam logic [6:0] SEG_BLANK = 7'h7F;
	localparam logic [6:0] SEG_A = 7'h08;
	localparam logic [6:0] SEG_C = 7'h46;
	localparam logic [6:0] SEG_E = 7'h06;
	localparam logic [6:0] SEG_D = 7'h21;
	localparam logic [6:0] SEG_I = 7'h4F;

	typedef struct packed {
		logic [7:0] code;
		logic [3:0] keys; // left, right, fire, start
	} keyRow_t;

	localparam keyRow_t KEY_TABLE [7] = '{
		'{8'h1C, 4'b1000}, // A make
		'{8'h55, 4'b1000}, // unknown byte
		'{8'hF0, 4'b1000},
		'{8'h23, 4'b1000}, // D release, A still held
		'{8'h4D, 4'b1010}, // P make
		'{8'hF0, 4'b1010},
		'{8'h4D, 4'b1000}
	};

	logic       CLOCK_50;
	logic       arstN;
	logic [7:0] scanByte;
	logic       scanValid;
	logic [6:0] HEX0, HEX1, HEX2, HEX3, HEX4, HEX5;
	logic [9:0] LEDR;
	logic [2:0] hitsSeen; // LEDR[9:7] seen during a wait
	int         errors = 0;
	int         checks = 0;
	int         cycleCount = 0;

	spaceInvaders #(.FRAME_CYCLES(FRAME_CYCLES), .SECOND_FRAMES(SECOND_FRAMES),
		.TIME_LIMIT(TIME_LIMIT), .WIN_SCORE(WIN_SCORE)) u_spaceInvaders (.CLOCK_50, .arstN,
		.scanByte, .scanValid, .HEX0, .HEX1, .HEX2, .HEX3, .HEX4, .HEX5, .LEDR);

	`include "tbScanTasks.svh"

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task checkValue(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task checkUpper(input logic [6:0] e5, input logic [6:0] e4, input logic [6:0] e3,
		input logic [6:0] e2);
		checkValue("HEX5", HEX5, e5);
		checkValue("HEX4", HEX4, e4);
		checkValue("HEX3", HEX3, e3);
		checkValue("HEX2", HEX2, e2);
	endtask

	task resetDut;
		@(posedge CLOCK_50);
		arstN <= 1'b0;
		scanValid <= 1'b0;
		repeat (2) @(posedge CLOCK_50);
		arstN <= 1'b1;
		@(negedge CLOCK_50);
	endtask

	// space make, then one more cycle so the phase is already play
	task startRound;
		sendByte(8'h29);
		@(negedge CLOCK_50);
	endtask

	initial begin
		arstN = 1'b0;
		scanByte = '0;
		scanValid = 1'b0;

		resetDut(); // state straight after reset
		checkValue("HEX0", HEX0, SEG_0);
		checkValue("HEX1", HEX1, SEG_0);
		checkUpper(SEG_BLANK, SEG_BLANK, SEG_0, SEG_0);
		checkValue("LEDR", LEDR, '0);

		resetDut();
		for (int i = 0; i < 7; i++)
			runKeyRow(KEY_TABLE[i]);

		resetDut(); // right held, round never started
		sendByte(8'h23);
		checkValue("LEDR[3:0]", LEDR[3:0], 4'b0100);
		waitTicks(60);
		checkUpper(SEG_BLANK, SEG_BLANK, SEG_0, SEG_0);

		resetDut(); // one second per 20 frames, lost after 3
		startRound();
		waitTicks(19);
		checkValue("HEX2", HEX2, SEG_0);
		waitTicks(1);
		checkValue("HEX2", HEX2, SEG_1);
		waitTicks(19);
		checkValue("HEX2", HEX2, SEG_1);
		waitTicks(1);
		checkValue("HEX2", HEX2, SEG_2);
		waitTicks(20);
		@(negedge CLOCK_50);
		checkUpper(SEG_D, SEG_I, SEG_E, SEG_BLANK);

		resetDut(); // ship at 80 shoots enemy 1
		startRound();
		sendByte(8'hF0);
		sendByte(8'h29);
		sendByte(8'h4D);
		waitForLed(8, 60, hitsSeen);
		checkValue("HEX0", HEX0, SEG_1);
		@(negedge CLOCK_50);
		checkUpper(SEG_A, SEG_C, SEG_E, SEG_D);

		resetDut(); // left held before start so every play tick moves the ship
		sendByte(8'h1C);
		sendByte(8'hF0);
		sendByte(8'h23);
		startRound();
		waitTicks(35);
		sendByte(8'hF0);
		waitTicks(1); // 36th move, ship now at 44
		sendByte(8'h1C);
		sendByte(8'h4D);
		checkValue("LEDR[3:0]", LEDR[3:0], 4'b0011);
		waitForLed(9, 60, hitsSeen);
		checkValue("LEDR[8] seen", hitsSeen[1], 1'b0);
		checkValue("HEX0", HEX0, SEG_1);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/spaceInvaders.sv */
`default_nettype none

module spaceInvaders import invadersPkg::*; #(
	parameter int FRAME_CYCLES = FRAME_CYCLES_DEF,
	parameter int SECOND_FRAMES = SECOND_FRAMES_DEF,
	parameter int TIME_LIMIT = TIME_LIMIT_DEF,
	parameter int WIN_SCORE = WIN_SCORE_DEF
) (
	input  wire        CLOCK_50,
	input  wire        arstN,
	input  wire  [7:0] scanByte,
	input  wire        scanValid,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3,
	output logic [6:0] HEX4,
	output logic [6:0] HEX5,
	output logic [9:0] LEDR
);

	keyState_t              keys;
	logic                   frameTick;
	gamePhase_t             phase;
	seconds_t               seconds;
	shot_t                  shot;
	logic                   shotHit;
	logic [NUM_ENEMIES-1:0] hitFlags;
	score_t                 score;
	logic                   winReached;
	seg7_t                  hexSeg [6];

	keyDecoder u_keyDecoder (.CLOCK_50, .arstN, .scanByte(scanCode_t'(scanByte)), .scanValid,
		.keys);

	roundControl #(.FRAME_CYCLES(FRAME_CYCLES), .SECOND_FRAMES(SECOND_FRAMES),
		.TIME_LIMIT(TIME_LIMIT)) u_roundControl (.CLOCK_50, .arstN, .keys, .winReached,
		.frameTick, .phase, .seconds);

	// ship column only feeds the bullet launch here
	shipBullet u_shipBullet (.CLOCK_50, .arstN, .frameTick, .phase, .keys, .shotHit, .shipX(),
		.shot);

	enemyField #(.WIN_SCORE(WIN_SCORE)) u_enemyField (.CLOCK_50, .arstN, .frameTick, .phase,
		.shot, .hitFlags, .shotHit, .score, .winReached);

	statusDisplay u_statusDisplay (.phase, .score, .seconds, .hex(hexSeg));

	assign {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} =
		{hexSeg[5], hexSeg[4], hexSeg[3], hexSeg[2], hexSeg[1], hexSeg[0]};

	// enemy 0 on LEDR9, key flags on the low four
	assign LEDR = {hitFlags[0], hitFlags[1], hitFlags[2], 3'b000, keys};

endmodule

`default_nettype wire

/* hdl/statusDisplay.sv */
`default_nettype none

module statusDisplay import invadersPkg::*; (
	input  wire gamePhase_t phase,
	input  wire score_t     score,
	input  wire seconds_t   seconds,
	output seg7_t           hex [6]
);

	seg7_t scoreTens, scoreUnits;
	seg7_t secTens, secUnits;

	// both counts stay below 64, so tens is at most 6
	assign scoreTens = SEG_DIGITS[int'(score) / 10];
	assign scoreUnits = SEG_DIGITS[int'(score) % 10];
	assign secTens = SEG_DIGITS[int'(seconds) / 10];
	assign secUnits = SEG_DIGITS[int'(seconds) % 10];

	always_comb begin
		hex[0] = scoreUnits;
		hex[1] = scoreTens;
		case (phase)
			phWon: begin // ACEd
				hex[5] = SEG_A;
				hex[4] = SEG_C;
				hex[3] = SEG_E;
				hex[2] = SEG_D;
			end
			phLost: begin // dIE
				hex[5] = SEG_D;
				hex[4] = SEG_I;
				hex[3] = SEG_E;
				hex[2] = SEG_BLANK;
			end
			default: begin
				hex[5] = SEG_BLANK;
				hex[4] = SEG_BLANK;
				hex[3] = secTens;
				hex[2] = secUnits;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/enemyField.sv */
`default_nettype none

module enemyField import invadersPkg::*; #(
	parameter int WIN_SCORE = WIN_SCORE_DEF
) (
	input  wire                    CLOCK_50,
	input  wire                    arstN,
	input  wire                    frameTick,
	input  wire  gamePhase_t       phase,
	input  wire  shot_t            shot,
	output logic [NUM_ENEMIES-1:0] hitFlags,
	output logic                   shotHit,
	output score_t                 score,
	output logic                   winReached
);

	objPos_t                enemy [NUM_ENEMIES];
	logic [NUM_ENEMIES-1:0] inBox;
	logic [NUM_ENEMIES-1:0] hitSel; // lowest numbered box only
	logic                   update;

	function automatic xCoord_t respawnX(input xCoord_t x);
		return xCoord_t'((int'(x) * RESPAWN_MUL + RESPAWN_ADD) % RESPAWN_MOD);
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_ENEMIES; i++) begin
			inBox[i] = shot.active
				&& shot.pos.x >= enemy[i].x && shot.pos.x < enemy[i].x + ENEMY_SIZE
				&& shot.pos.y >= enemy[i].y && shot.pos.y < enemy[i].y + ENEMY_SIZE;
		end
	end

	assign hitSel = inBox & (~inBox + 1'b1);
	assign shotHit = |inBox;
	assign winReached = (score == score_t'(WIN_SCORE));
	assign update = frameTick && phase == phPlay;

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NUM_ENEMIES; i++) begin
				enemy[i].x <= ENEMY_START_X[i];
				enemy[i].y <= ENEMY_START_Y[i];
			end
			hitFlags <= '0;
			score <= '0;
		end else if (update) begin
			for (int i = 0; i < NUM_ENEMIES; i++) begin
				// shot down or off the bottom, back to the top row
				if (hitSel[i] || enemy[i].y >= SCREEN_HEIGHT) begin
					enemy[i].x <= respawnX(enemy[i].x);
					enemy[i].y <= '0;
				end else begin
					enemy[i].y <= enemy[i].y + 1'b1;
				end
			end
			hitFlags <= hitSel; // held for one frame
			if (|hitSel && !winReached)
				score <= score + 1'b1;
		end
	end

	oneHit: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		$onehot0(hitFlags))
		else $error("more than one enemy hit in a frame");

endmodule

`default_nettype wire

/* hdl/shipBullet.sv */
`default_nettype none

module shipBullet import invadersPkg::*; (
	input  wire              CLOCK_50,
	input  wire              arstN,
	input  wire              frameTick,
	input  wire  gamePhase_t phase,
	input  wire  keyState_t  keys,
	input  wire              shotHit,
	output xCoord_t          shipX,
	output shot_t            shot
);

	logic update;

	assign update = frameTick && phase == phPlay;

	// ship column, right wins over left
	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			shipX <= xCoord_t'(SHIP_START_X);
		end else if (update) begin
			if (keys.right && shipX < SCREEN_WIDTH - SHIP_WIDTH)
				shipX <= shipX + 1'b1;
			else if (keys.left && shipX > 0)
				shipX <= shipX - 1'b1;
		end
	end

	// one bullet in flight at most
	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			shot.active <= 1'b0;
			shot.pos.x <= xCoord_t'(SHIP_START_X);
			shot.pos.y <= yCoord_t'(BULLET_START_Y);
		end else if (update) begin
			if (shot.active) begin
				if (shotHit || shot.pos.y < 2)
					shot.active <= 1'b0;
				else
					shot.pos.y <= shot.pos.y - yCoord_t'(BULLET_STEP);
			end else if (keys.fire) begin
				shot.active <= 1'b1;
				shot.pos.x <= shipX; // column before this frame's move
				shot.pos.y <= yCoord_t'(BULLET_START_Y);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/roundControl.sv */
`default_nettype none

module roundControl import invadersPkg::*; #(
	parameter int FRAME_CYCLES = FRAME_CYCLES_DEF,
	parameter int SECOND_FRAMES = SECOND_FRAMES_DEF,
	parameter int TIME_LIMIT = TIME_LIMIT_DEF
) (
	input  wire             CLOCK_50,
	input  wire             arstN,
	input  wire  keyState_t keys,
	input  wire             winReached,
	output logic            frameTick,
	output gamePhase_t      phase,
	output seconds_t        seconds
);

	localparam int FRAME_W = $clog2(FRAME_CYCLES + 1);
	localparam int SEC_W = $clog2(SECOND_FRAMES + 1);

	logic [FRAME_W-1:0] frameCnt;
	logic [SEC_W-1:0]   tickCnt; // frames into the current second

	assign frameTick = (frameCnt == FRAME_W'(FRAME_CYCLES - 1));

	// free running frame divider
	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN)
			frameCnt <= '0;
		else if (frameTick)
			frameCnt <= '0;
		else
			frameCnt <= frameCnt + 1'b1;
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			tickCnt <= '0;
			seconds <= '0;
		end else if (frameTick && phase == phPlay) begin
			if (tickCnt == SEC_W'(SECOND_FRAMES - 1)) begin
				tickCnt <= '0;
				seconds <= seconds + 1'b1;
			end else begin
				tickCnt <= tickCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			phase <= phIdle;
		end else begin
			case (phase)
				phIdle: if (keys.start) phase <= phPlay;
				phPlay: begin
					if (winReached)
						phase <= phWon; // a win beats the clock
					else if (seconds == seconds_t'(TIME_LIMIT))
						phase <= phLost;
				end
				default: ; // won and lost wait for reset
			endcase
		end
	end

	endSticky: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		(phase inside {phWon, phLost}) |=> $stable(phase))
		else $error("round left its end phase without reset");

endmodule

`default_nettype wire

/* hdl/keyDecoder.sv */
`default_nettype none

module keyDecoder import invadersPkg::*; (
	input  wire             CLOCK_50,
	input  wire             arstN,
	input  wire  scanCode_t scanByte,
	input  wire             scanValid,
	output keyState_t       keys
);

	keyFsm_t   state;
	keyState_t codeMask; // which flag this byte names, zero if unknown

	always_comb begin
		codeMask = '0;
		case (scanByte)
			scA:     codeMask.left = 1'b1;
			scD:     codeMask.right = 1'b1;
			scP:     codeMask.fire = 1'b1;
			scSpace: codeMask.start = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			state <= ksIdle;
			keys <= '0;
		end else if (scanValid) begin
			case (state)
				ksIdle: begin
					if (|codeMask) begin
						keys <= keys | codeMask; // make code
						state <= ksMake;
					end
				end
				ksMake: begin
					if (scanByte == scBreak)
						state <= ksBreak;
				end
				ksBreak: begin
					// release clears only the named key
					if (|codeMask) begin
						keys <= keys & ~codeMask;
						state <= ksIdle;
					end
				end
				default: state <= ksIdle;
			endcase
		end
	end

	stateLegal: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		state inside {ksIdle, ksMake, ksBreak})
		else $error("keyDecoder state out of range");

endmodule

`default_nettype wire

/* hdl/invadersPkg.sv */
`default_nettype none

package invadersPkg;

	// playfield
	localparam int SCREEN_WIDTH = 160;
	localparam int SCREEN_HEIGHT = 120;

	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;

	typedef struct packed {
		xCoord_t x;
		yCoord_t y;
	} objPos_t;

	// ship and bullet
	localparam int SHIP_WIDTH = 8;
	localparam int SHIP_START_X = 80;
	localparam int BULLET_START_Y = 113;
	localparam int BULLET_STEP = 2; // rows per frame

	typedef struct packed {
		logic    active;
		objPos_t pos;
	} shot_t;

	// enemies
	localparam int ENEMY_SIZE = 8;
	localparam int NUM_ENEMIES = 3;
	localparam xCoord_t ENEMY_START_X [NUM_ENEMIES] = '{8'd40, 8'd80, 8'd120};
	localparam yCoord_t ENEMY_START_Y [NUM_ENEMIES] = '{7'd10, 7'd25, 7'd40};

	// pseudo-random respawn column
	localparam int RESPAWN_MUL = 7;
	localparam int RESPAWN_ADD = 13;
	localparam int RESPAWN_MOD = 152;

	// top-level defaults, 50 MHz board clock
	localparam int FRAME_CYCLES_DEF = 833333; // ~60 Hz
	localparam int SECOND_FRAMES_DEF = 60;
	localparam int TIME_LIMIT_DEF = 40;
	localparam int WIN_SCORE_DEF = 15;

	// PS/2 set 2 scan codes
	typedef enum logic [7:0] {
		scA     = 8'h1C,
		scD     = 8'h23,
		scP     = 8'h4D,
		scSpace = 8'h29,
		scBreak = 8'hF0
	} scanCode_t;

	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic start;
	} keyState_t;

	typedef enum logic [1:0] {ksIdle, ksMake, ksBreak} keyFsm_t;

	typedef enum logic [1:0] {phIdle, phPlay, phWon, phLost} gamePhase_t;

	typedef logic [5:0] score_t;
	typedef logic [5:0] seconds_t;

	// active low, bit 0 is segment a
	typedef logic [6:0] seg7_t;

	localparam seg7_t SEG_DIGITS [10] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
	};

	localparam seg7_t SEG_BLANK = 7'b1111111;
	localparam seg7_t SEG_A = 7'b0001000;
	localparam seg7_t SEG_C = 7'b1000110;
	localparam seg7_t SEG_E = 7'b0000110;
	localparam seg7_t SEG_D = 7'b0100001; // lower case d
	localparam seg7_t SEG_I = 7'b1001111;

endpackage

`default_nettype wire
